// ==== src/ptw_pkg.sv ====
// Sv39 walker widths, PTE field positions, level constants and shared packed structs
`default_nettype none

package ptw_pkg;

	localparam int VA_BITS = 39;
	localparam int PAGE_OFFSET = 12;
	localparam int VPN_BITS = VA_BITS - PAGE_OFFSET;
	localparam int NPHYS = 56;
	localparam int PPN_BITS = NPHYS - PAGE_OFFSET;
	localparam int LINE_BITS = 512;
	localparam int LINE_OFFSET = 6;
	localparam int LINE_TAG_BITS = NPHYS - LINE_OFFSET;	// line address
	localparam int PTE_BITS = 64;
	localparam int PTES_PER_LINE = LINE_BITS / PTE_BITS;
	localparam int PTE_IDX_BITS = LINE_OFFSET - 3;
	localparam int LEVELS = 3;
	localparam int LEVEL_IDX_BITS = 9;
	localparam int SIDES = 2;
	localparam int TID_BITS = 5;
	localparam int PERM_BITS = 7;

	// bit positions inside a PTE
	localparam int PTE_V = 0;
	localparam int PTE_R = 1;
	localparam int PTE_W = 2;
	localparam int PTE_X = 3;
	localparam int PTE_U = 4;
	localparam int PTE_G = 5;
	localparam int PTE_A = 6;
	localparam int PTE_D = 7;
	localparam int PTE_PPN_LSB = 10;

	typedef enum logic {
		SIDE_D = 1'b0,
		SIDE_I = 1'b1
	} side_t;

	typedef logic [1:0] level_t;	// 0 is the root

	localparam level_t LAST_LEVEL = level_t'(LEVELS - 1);

	typedef struct packed {
		logic [VPN_BITS-1:0] vpn;
		logic [TID_BITS-1:0] tid;	// i side uses bit 0 only
	} ptw_req_t;

	typedef struct packed {
		logic vm_on;
		logic [PPN_BITS-1:0] root_ppn;
	} ptw_config_t;

	// names one cache slot
	typedef struct packed {
		side_t side;
		level_t level;
	} mem_trans_t;

	typedef struct packed {
		logic [LINE_TAG_BITS-1:0] line;
		logic [PTE_IDX_BITS-1:0] word;	// PTE within the line
	} mem_req_t;

	typedef struct packed {
		logic v;
		logic leaf;
		logic [PERM_BITS-1:0] perm;	// G A D U W R X
		logic [PPN_BITS-1:0] ppn;
	} pte_fields_t;

	typedef struct packed {
		side_t side;
		logic [TID_BITS-1:0] tid;
		logic [VPN_BITS-1:0] vpn;
		logic [PPN_BITS-1:0] ppn;
		logic [PERM_BITS-1:0] perm;
		logic is_2m;
		logic is_1g;
		logic valid;
		logic fault;	// memory fail during the walk
	} ptw_resp_t;

endpackage

`default_nettype wire

// ==== src/pte_line_cache.sv ====
// six-slot page-table line store with tags, valid bits, memory fill and snoop invalidate
`timescale 1ns/1ns
`default_nettype none

module pte_line_cache (
	input wire clk,
	input wire reset,

	input wire ptw_pkg::mem_trans_t i_lookup_slot,
	input wire [ptw_pkg::LINE_TAG_BITS-1:0] i_lookup_tag,
	output logic o_hit,
	output logic [ptw_pkg::LINE_BITS-1:0] o_line,

	input wire i_fill_valid,
	input wire ptw_pkg::mem_trans_t i_fill_trans,
	input wire [ptw_pkg::LINE_BITS-1:0] i_fill_line,
	input wire [ptw_pkg::LINE_TAG_BITS-1:0] i_fill_tag,

	input wire i_snoop,
	input wire [ptw_pkg::LINE_TAG_BITS-1:0] i_snoop_addr
);
	import ptw_pkg::*;

	logic [LINE_BITS-1:0] line_mem [SIDES][LEVELS];
	logic [LINE_TAG_BITS-1:0] tag_mem [SIDES][LEVELS];
	logic [SIDES-1:0][LEVELS-1:0] slot_valid;
	logic [SIDES-1:0][LEVELS-1:0] fill_sel;
	logic [SIDES-1:0][LEVELS-1:0] snoop_sel;
	logic snoop_on_fill;
	logic slot_ok;

	// fill slot decode, one per side and level
	for (genvar s = 0; s < SIDES; s++) begin : g_side
		for (genvar l = 0; l < LEVELS; l++) begin : g_level
			assign fill_sel[s][l] = i_fill_valid &&
				i_fill_trans.side == side_t'(s) &&
				i_fill_trans.level == level_t'(l);
			assign snoop_sel[s][l] = i_snoop && i_snoop_addr == tag_mem[s][l];
		end
	end

	// a snoop to the line being filled wins
	assign snoop_on_fill = i_snoop && i_snoop_addr == i_fill_tag;

	always_ff @(posedge clk) begin
		if (reset) begin
			slot_valid <= '0;
		end else begin
			for (int s = 0; s < SIDES; s++) begin
				for (int l = 0; l < LEVELS; l++) begin
					if (fill_sel[s][l]) begin
						slot_valid[s][l] <= !snoop_on_fill;
					end else if (snoop_sel[s][l]) begin
						slot_valid[s][l] <= 1'b0;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < SIDES; s++) begin
			for (int l = 0; l < LEVELS; l++) begin
				if (fill_sel[s][l]) begin
					line_mem[s][l] <= i_fill_line;
					tag_mem[s][l] <= i_fill_tag;
				end
			end
		end
	end

	// combinational lookup
	assign slot_ok = i_lookup_slot.level <= LAST_LEVEL;

	always_comb begin
		o_hit = 1'b0;
		o_line = line_mem[i_lookup_slot.side][i_lookup_slot.level];
		if (slot_ok) begin
			o_hit = slot_valid[i_lookup_slot.side][i_lookup_slot.level] &&
				tag_mem[i_lookup_slot.side][i_lookup_slot.level] == i_lookup_tag;
		end
	end

endmodule

`default_nettype wire

// ==== src/pte_decode.sv ====
// PTE select from a cached line and split into valid, leaf, permission and PPN fields
`timescale 1ns/1ns
`default_nettype none

module pte_decode (
	input wire [ptw_pkg::LINE_BITS-1:0] i_line,
	input wire [ptw_pkg::PTE_IDX_BITS-1:0] i_pte_index,
	output ptw_pkg::pte_fields_t o_pte
);
	import ptw_pkg::*;

	logic [PTE_BITS-1:0] pte;

	// one of eight 64-bit entries
	always_comb begin
		pte = '0;
		for (int i = 0; i < PTES_PER_LINE; i++) begin
			if (i_pte_index == PTE_IDX_BITS'(i)) begin
				pte = i_line[i*PTE_BITS +: PTE_BITS];
			end
		end
	end

	always_comb begin
		o_pte.v = pte[PTE_V];
		o_pte.leaf = pte[PTE_R] | pte[PTE_W] | pte[PTE_X];	// R=W=X=0 is a pointer
		o_pte.perm = {
			pte[PTE_G],
			pte[PTE_A],
			pte[PTE_D],
			pte[PTE_U],
			pte[PTE_W],
			pte[PTE_R],
			pte[PTE_X]
		};
		o_pte.ppn = pte[PTE_PPN_LSB +: PPN_BITS];
	end

endmodule

`default_nettype wire

// ==== src/walk_ctrl.sv ====
// request arbitration, Sv39 walk FSM, memory fetch requests and response register
`timescale 1ns/1ns
`default_nettype none

module walk_ctrl (
	input wire clk,
	input wire reset,
	input wire ptw_pkg::ptw_config_t i_config,

	input wire i_d_req,
	input wire ptw_pkg::ptw_req_t i_d_req_data,
	output logic o_d_ack,
	input wire i_i_req,
	input wire ptw_pkg::ptw_req_t i_i_req_data,
	output logic o_i_ack,

	output logic o_resp_valid,
	output ptw_pkg::ptw_resp_t o_resp,

	output logic o_mem_req,
	output ptw_pkg::mem_req_t o_mem_addr,
	output ptw_pkg::mem_trans_t o_mem_trans,
	input wire i_mem_ack,
	input wire i_mem_fail,
	input wire i_mem_data_valid,
	input wire ptw_pkg::mem_trans_t i_mem_data_trans,

	output ptw_pkg::mem_trans_t o_lookup_slot,
	output logic [ptw_pkg::LINE_TAG_BITS-1:0] o_lookup_tag,
	input wire i_hit,
	input wire ptw_pkg::pte_fields_t i_pte,
	output logic [ptw_pkg::PTE_IDX_BITS-1:0] o_pte_index
);
	import ptw_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_LOOKUP,
		S_FETCH,
		S_WAIT
	} state_t;

	state_t r_state, c_state;
	side_t r_side;
	level_t r_level;
	logic [TID_BITS-1:0] r_tid;
	logic [VPN_BITS-1:0] r_vpn;
	logic [PPN_BITS-1:0] r_base_ppn;	// table at the current level

	logic idle;
	ptw_req_t acc_req;
	logic [TID_BITS-1:0] acc_tid;
	logic [LEVEL_IDX_BITS-1:0] vpn_slice;
	logic [PPN_BITS-1:0] leaf_ppn;
	logic fill_done;
	logic descend;
	logic resp_fire;
	ptw_resp_t c_resp;

	assign idle = r_state == S_IDLE;
	assign o_d_ack = idle && i_d_req;
	assign o_i_ack = idle && i_i_req && !i_d_req;	// d side wins

	assign acc_req = o_d_ack ? i_d_req_data : i_i_req_data;
	assign acc_tid = o_d_ack ? i_d_req_data.tid : TID_BITS'(i_i_req_data.tid[0]);

	always_comb begin
		case (r_level)
		2'd0: vpn_slice = r_vpn[2*LEVEL_IDX_BITS +: LEVEL_IDX_BITS];
		2'd1: vpn_slice = r_vpn[LEVEL_IDX_BITS +: LEVEL_IDX_BITS];
		default: vpn_slice = r_vpn[0 +: LEVEL_IDX_BITS];
		endcase
	end

	// superpages fill the low ppn slices from the vpn
	always_comb begin
		case (r_level)
		2'd0: leaf_ppn = {i_pte.ppn[PPN_BITS-1:2*LEVEL_IDX_BITS],
				r_vpn[2*LEVEL_IDX_BITS-1:0]};
		2'd1: leaf_ppn = {i_pte.ppn[PPN_BITS-1:LEVEL_IDX_BITS],
				r_vpn[LEVEL_IDX_BITS-1:0]};
		default: leaf_ppn = i_pte.ppn;
		endcase
	end

	// PTE address is table base plus 8 * vpn slice
	assign o_mem_addr = {r_base_ppn, vpn_slice};
	assign o_mem_trans = '{side: r_side, level: r_level};
	assign o_mem_req = r_state == S_FETCH;
	assign o_lookup_slot = o_mem_trans;
	assign o_lookup_tag = o_mem_addr.line;
	assign o_pte_index = o_mem_addr.word;
	assign fill_done = i_mem_data_valid && i_mem_data_trans == o_mem_trans;

	assign descend = r_state == S_LOOKUP && i_hit && i_pte.v && !i_pte.leaf &&
		r_level != LAST_LEVEL;

	always_comb begin
		c_state = r_state;
		resp_fire = 1'b0;
		c_resp = '0;
		c_resp.side = r_side;
		c_resp.tid = r_tid;
		c_resp.vpn = r_vpn;
		case (r_state)
		S_IDLE: if (o_d_ack || o_i_ack) begin
			if (i_config.vm_on) begin
				c_state = S_LOOKUP;
			end else begin
				resp_fire = 1'b1;	// translation off, invalid at once
				c_resp.side = o_d_ack ? SIDE_D : SIDE_I;
				c_resp.tid = acc_tid;
				c_resp.vpn = acc_req.vpn;
			end
		end
		S_LOOKUP: if (!i_hit) begin
			c_state = S_FETCH;
		end else if (!i_pte.v || (!i_pte.leaf && r_level == LAST_LEVEL)) begin
			resp_fire = 1'b1;
			c_state = S_IDLE;
		end else if (i_pte.leaf) begin
			resp_fire = 1'b1;
			c_resp.valid = 1'b1;
			c_resp.ppn = leaf_ppn;
			c_resp.perm = i_pte.perm;
			c_resp.is_1g = r_level == 2'd0;
			c_resp.is_2m = r_level == 2'd1;
			c_state = S_IDLE;
		end
		S_FETCH: if (i_mem_fail) begin
			resp_fire = 1'b1;
			c_resp.fault = 1'b1;
			c_state = S_IDLE;
		end else if (i_mem_ack) begin
			c_state = S_WAIT;
		end
		S_WAIT: if (fill_done) begin
			c_state = S_LOOKUP;	// retry with the new line
		end
		default: c_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r_state <= S_IDLE;
			o_resp_valid <= 1'b0;
		end else begin
			r_state <= c_state;
			o_resp_valid <= resp_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (o_d_ack || o_i_ack) begin
			r_side <= o_d_ack ? SIDE_D : SIDE_I;
			r_tid <= acc_tid;
			r_vpn <= acc_req.vpn;
			r_level <= '0;
			r_base_ppn <= i_config.root_ppn;
		end else if (descend) begin
			r_level <= r_level + 2'd1;
			r_base_ppn <= i_pte.ppn;	// next table
		end
		if (resp_fire) begin
			o_resp <= c_resp;
		end
	end

endmodule

`default_nettype wire

// ==== src/ptw_top.sv ====
// page-table walker top: walk controller, PTE line cache and PTE decoder
`timescale 1ns/1ns
`default_nettype none

module ptw_top (
	input wire clk,
	input wire reset,
	input wire ptw_pkg::ptw_config_t i_config,

	input wire i_d_req,
	input wire ptw_pkg::ptw_req_t i_d_req_data,
	output logic o_d_ack,

	input wire i_i_req,
	input wire ptw_pkg::ptw_req_t i_i_req_data,
	output logic o_i_ack,

	output logic o_resp_valid,
	output ptw_pkg::ptw_resp_t o_resp,

	output logic o_mem_req,
	output ptw_pkg::mem_req_t o_mem_addr,
	output ptw_pkg::mem_trans_t o_mem_trans,
	input wire i_mem_ack,
	input wire i_mem_fail,

	input wire i_mem_data_valid,
	input wire ptw_pkg::mem_trans_t i_mem_data_trans,
	input wire [ptw_pkg::LINE_BITS-1:0] i_mem_data,

	input wire i_snoop,
	input wire [ptw_pkg::LINE_TAG_BITS-1:0] i_snoop_addr
);
	import ptw_pkg::*;

	mem_trans_t lookup_slot;
	logic [LINE_TAG_BITS-1:0] lookup_tag;
	logic lookup_hit;
	logic [LINE_BITS-1:0] lookup_line;
	logic [PTE_IDX_BITS-1:0] pte_index;
	pte_fields_t pte;

	walk_ctrl u_walk_ctrl (
		.clk(clk),
		.reset(reset),
		.i_config(i_config),
		.i_d_req(i_d_req),
		.i_d_req_data(i_d_req_data),
		.o_d_ack(o_d_ack),
		.i_i_req(i_i_req),
		.i_i_req_data(i_i_req_data),
		.o_i_ack(o_i_ack),
		.o_resp_valid(o_resp_valid),
		.o_resp(o_resp),
		.o_mem_req(o_mem_req),
		.o_mem_addr(o_mem_addr),
		.o_mem_trans(o_mem_trans),
		.i_mem_ack(i_mem_ack),
		.i_mem_fail(i_mem_fail),
		.i_mem_data_valid(i_mem_data_valid),
		.i_mem_data_trans(i_mem_data_trans),
		.o_lookup_slot(lookup_slot),
		.o_lookup_tag(lookup_tag),
		.i_hit(lookup_hit),
		.i_pte(pte),
		.o_pte_index(pte_index)
	);

	// fill tag is the held fetch address, only one walk in flight
	pte_line_cache u_pte_line_cache (
		.clk(clk),
		.reset(reset),
		.i_lookup_slot(lookup_slot),
		.i_lookup_tag(lookup_tag),
		.o_hit(lookup_hit),
		.o_line(lookup_line),
		.i_fill_valid(i_mem_data_valid),
		.i_fill_trans(i_mem_data_trans),
		.i_fill_line(i_mem_data),
		.i_fill_tag(o_mem_addr.line),
		.i_snoop(i_snoop),
		.i_snoop_addr(i_snoop_addr)
	);

	pte_decode u_pte_decode (
		.i_line(lookup_line),
		.i_pte_index(pte_index),
		.o_pte(pte)
	);

endmodule

`default_nettype wire

// ==== sim/tb_ptw_mem.svh ====
// sparse PTE memory, table-building tasks and reference Sv39 walk
`ifndef TB_PTW_MEM_SVH
`define TB_PTW_MEM_SVH

logic [63:0] pte_mem [logic [52:0]];	// keyed by PTE word address
logic [PPN_BITS-1:0] next_table = 44'h1000;

function automatic logic [LEVEL_IDX_BITS-1:0] slice_of(logic [VPN_BITS-1:0] vpn, int lvl);
	return vpn[LEVEL_IDX_BITS*(2-lvl) +: LEVEL_IDX_BITS];
endfunction

function automatic logic [63:0] rd_pte(logic [52:0] key);
	return pte_mem.exists(key) ? pte_mem[key] : 64'h0;
endfunction

// memory write, followed by a snoop of its line
task automatic write_pte(logic [52:0] key, logic [63:0] val);
	pte_mem[key] = val;
	@(posedge clk);
	i_snoop <= 1'b1;
	i_snoop_addr <= key[52:3];
	@(posedge clk);
	i_snoop <= 1'b0;
endtask

// base ppn of the table used at level lvl
function automatic logic [PPN_BITS-1:0] table_base(logic [VPN_BITS-1:0] vpn, int lvl);
	logic [PPN_BITS-1:0] base;
	logic [63:0] e;
	base = cfg.root_ppn;
	for (int l = 0; l < lvl; l++) begin
		e = rd_pte({base, slice_of(vpn, l)});
		base = e[53:10];
	end
	return base;
endfunction

task automatic map_page(logic [VPN_BITS-1:0] vpn, int leaf_lvl, logic [PPN_BITS-1:0] ppn,
		logic [7:0] flags);
	logic [PPN_BITS-1:0] base;
	logic [52:0] key;
	logic [63:0] e;
	base = cfg.root_ppn;
	for (int l = 0; l < leaf_lvl; l++) begin
		key = {base, slice_of(vpn, l)};
		e = rd_pte(key);
		if (!e[0] || e[3:1] != 3'b000) begin	// need a fresh table here
			write_pte(key, {10'b0, next_table, 10'h001});
			base = next_table;
			next_table = next_table + 1;
		end else begin
			base = e[53:10];
		end
	end
	write_pte({base, slice_of(vpn, leaf_lvl)}, {10'b0, ppn, 2'b00, flags});
endtask

function automatic ptw_resp_t ref_walk(side_t side, ptw_req_t r, ptw_config_t c);
	ptw_resp_t res;
	logic [PPN_BITS-1:0] base;
	logic [63:0] e;
	res = '0;
	res.side = side;
	res.tid = (side == SIDE_I) ? TID_BITS'(r.tid[0]) : r.tid;
	res.vpn = r.vpn;
	if (!c.vm_on) return res;
	base = c.root_ppn;
	for (int l = 0; l < LEVELS; l++) begin
		e = rd_pte({base, slice_of(r.vpn, l)});
		if (!e[0]) return res;
		if (e[3:1] != 3'b000) begin
			res.ppn = e[53:10];
			if (l == 0) res.ppn[17:0] = r.vpn[17:0];	// 1G page
			if (l == 1) res.ppn[8:0] = r.vpn[8:0];
			res.perm = {e[5], e[6], e[7], e[4], e[2], e[1], e[3]};
			res.is_1g = (l == 0);
			res.is_2m = (l == 1);
			res.valid = 1'b1;
			return res;
		end
		if (l == LEVELS - 1) return res;	// pointer at the last level
		base = e[53:10];
	end
	return res;
endfunction

`endif

// ==== sim/tb_ptw.sv ====
// testbench top: clock, reset, request stimulus, memory responder, response checker
`timescale 1ns/1ns
`default_nettype none

module tb_ptw;
	import ptw_pkg::*;

	localparam int LIMIT = 2000;

	logic clk = 1'b0;
	logic reset;
	ptw_config_t cfg;
	logic i_d_req, i_i_req;
	ptw_req_t i_d_req_data, i_i_req_data;
	logic o_d_ack, o_i_ack, o_resp_valid;
	ptw_resp_t o_resp;
	logic o_mem_req, i_mem_ack, i_mem_fail, i_mem_data_valid;
	mem_req_t o_mem_addr;
	mem_trans_t o_mem_trans, i_mem_data_trans;
	logic [LINE_BITS-1:0] i_mem_data;
	logic i_snoop;
	logic [LINE_TAG_BITS-1:0] i_snoop_addr;

	ptw_resp_t exp_q[$];
	string name_q[$];
	int mismatches = 0;
	int timeouts = 0;
	int fetch_count = 0;
	logic fail_next = 1'b0;
	side_t cur_side = SIDE_D;	// walk in flight
	logic [VPN_BITS-1:0] cur_vpn = '0;
	string cur_name = "";

	`include "tb_ptw_mem.svh"

	ptw_top u_dut (
		.clk(clk), .reset(reset), .i_config(cfg),
		.i_d_req(i_d_req), .i_d_req_data(i_d_req_data), .o_d_ack(o_d_ack),
		.i_i_req(i_i_req), .i_i_req_data(i_i_req_data), .o_i_ack(o_i_ack),
		.o_resp_valid(o_resp_valid), .o_resp(o_resp),
		.o_mem_req(o_mem_req), .o_mem_addr(o_mem_addr), .o_mem_trans(o_mem_trans),
		.i_mem_ack(i_mem_ack), .i_mem_fail(i_mem_fail),
		.i_mem_data_valid(i_mem_data_valid), .i_mem_data_trans(i_mem_data_trans),
		.i_mem_data(i_mem_data), .i_snoop(i_snoop), .i_snoop_addr(i_snoop_addr)
	);

	initial begin
		forever #2 clk = ~clk;
	end

	// memory responder, random accept delay and data delay
	initial begin
		mem_req_t addr;
		mem_req_t exp_addr;
		mem_trans_t trans;
		logic failed;
		forever begin
			@(negedge clk);
			if (o_mem_req) begin
				addr = o_mem_addr;
				trans = o_mem_trans;
				failed = fail_next;
				exp_addr = '0;
				if (trans.level <= LAST_LEVEL) begin	// PTE address of the current walk
					exp_addr = {table_base(cur_vpn, int'(trans.level)),
						slice_of(cur_vpn, int'(trans.level))};
				end
				assert ({trans.side, addr} === {cur_side, exp_addr}) else begin
					mismatches++;
					$display("[FAIL] %s fetch expected %h actual %h", cur_name,
						{cur_side, exp_addr}, {trans.side, addr});
				end
				repeat ($urandom % 3) @(negedge clk);
				@(posedge clk);
				if (failed) i_mem_fail <= 1'b1;
				else i_mem_ack <= 1'b1;
				fetch_count++;
				@(posedge clk);
				i_mem_ack <= 1'b0;
				i_mem_fail <= 1'b0;
				fail_next = 1'b0;
				if (!failed) begin
					repeat ($urandom % 4) @(posedge clk);
					for (int i = 0; i < PTES_PER_LINE; i++) begin
						i_mem_data[i*PTE_BITS +: PTE_BITS] <= rd_pte({addr.line, 3'(i)});
					end
					i_mem_data_trans <= trans;
					i_mem_data_valid <= 1'b1;
					@(posedge clk);
					i_mem_data_valid <= 1'b0;
				end
			end
		end
	end

	// compares every response with the head of the expected queue
	initial begin
		ptw_resp_t exp;
		string name;
		forever begin
			@(negedge clk);
			if (o_resp_valid) begin
				assert (exp_q.size() != 0) else begin
					mismatches++;
					$display("response arrived with nothing expected: %h", o_resp);
				end
				if (exp_q.size() != 0) begin
					exp = exp_q.pop_front();
					name = name_q.pop_front();
					assert (o_resp === exp) else begin
						mismatches++;
						$display("[FAIL] %s expected %h actual %h", name, exp, o_resp);
					end
				end
			end
		end
	end

	task automatic wait_done(string name);
		int cnt;
		cnt = 0;
		while (exp_q.size() != 0 && cnt < LIMIT) begin
			@(negedge clk);
			cnt++;
		end
		if (exp_q.size() != 0) begin
			timeouts++;
			$display("timeout: no response for %s", name);
			exp_q.delete();
			name_q.delete();
		end
	endtask

	// drives one or both sides, fault_exp marks an expected memory fail
	task automatic issue(logic do_d, ptw_req_t dreq, logic do_i, ptw_req_t ireq,
			string name, logic fault_exp = 1'b0);
		ptw_resp_t e;
		logic pend_d, pend_i;
		int cnt;
		if (do_d) begin
			e = ref_walk(SIDE_D, dreq, cfg);
			exp_q.push_back(e);
			name_q.push_back(name);
		end
		if (do_i) begin
			e = ref_walk(SIDE_I, ireq, cfg);
			exp_q.push_back(e);
			name_q.push_back(name);
		end
		if (fault_exp) begin
			e = exp_q.pop_back();
			e.ppn = '0;
			e.perm = '0;
			e.is_1g = 1'b0;
			e.is_2m = 1'b0;
			e.valid = 1'b0;
			e.fault = 1'b1;
			exp_q.push_back(e);
		end
		@(posedge clk);
		i_d_req <= do_d;
		i_d_req_data <= dreq;
		i_i_req <= do_i;
		i_i_req_data <= ireq;
		pend_d = do_d;
		pend_i = do_i;
		cnt = 0;
		while ((pend_d || pend_i) && cnt < LIMIT) begin
			@(negedge clk);
			cnt++;
			if (pend_d && o_d_ack) begin
				pend_d = 1'b0;
				cur_side = SIDE_D;
				cur_vpn = dreq.vpn;
				cur_name = name;
				@(posedge clk);
				i_d_req <= 1'b0;
			end else if (pend_i && o_i_ack) begin
				pend_i = 1'b0;
				cur_side = SIDE_I;
				cur_vpn = ireq.vpn;
				cur_name = name;
				@(posedge clk);
				i_i_req <= 1'b0;
			end
		end
		if (pend_d || pend_i) begin
			timeouts++;
			$display("timeout: request never acknowledged in %s", name);
			i_d_req <= 1'b0;
			i_i_req <= 1'b0;
		end
		wait_done(name);
	endtask

	function automatic ptw_req_t rand_req();
		ptw_req_t r;
		r.vpn = VPN_BITS'($urandom);
		r.tid = TID_BITS'($urandom);
		return r;
	endfunction

	function automatic logic [7:0] rand_flags();
		return 8'($urandom) | 8'h03;	// valid and readable
	endfunction

	initial begin
		ptw_req_t r, r2;
		int fc;
		void'($urandom(26));
		reset = 1'b1;
		cfg = '{vm_on: 1'b1, root_ppn: 44'h100};
		i_d_req = 1'b0;
		i_i_req = 1'b0;
		i_d_req_data = '0;
		i_i_req_data = '0;
		i_mem_ack = 1'b0;
		i_mem_fail = 1'b0;
		i_mem_data_valid = 1'b0;
		i_mem_data_trans = '0;
		i_mem_data = '0;
		i_snoop = 1'b0;
		i_snoop_addr = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		for (int k = 0; k < 8; k++) begin
			r = rand_req();
			map_page(r.vpn, 2, PPN_BITS'({$urandom, $urandom}), rand_flags());
			issue(k % 2 == 0, r, k % 2 == 1, r, "map_4k");
		end
		for (int k = 0; k < 6; k++) begin
			r = rand_req();
			map_page(r.vpn, k % 2, PPN_BITS'({$urandom, $urandom}), rand_flags());
			issue(1'b1, r, 1'b0, r, k % 2 ? "map_2m" : "map_1g");
		end

		for (int l = 0; l < LEVELS; l++) begin
			r = rand_req();
			map_page(r.vpn, 2, PPN_BITS'($urandom), rand_flags());
			write_pte({table_base(r.vpn, l), slice_of(r.vpn, l)}, 64'h0);
			issue(1'b1, r, 1'b0, r, "invalid_pte");
		end
		r = rand_req();
		map_page(r.vpn, 2, PPN_BITS'($urandom), rand_flags());
		write_pte({table_base(r.vpn, 2), slice_of(r.vpn, 2)}, 64'h401);
		issue(1'b0, r, 1'b1, r, "pointer_at_last_level");
		@(posedge clk);
		cfg.vm_on <= 1'b0;
		@(posedge clk);
		issue(1'b1, r, 1'b0, r, "translation_off");
		@(posedge clk);
		cfg.vm_on <= 1'b1;
		@(posedge clk);

		r = rand_req();
		map_page(r.vpn, 2, PPN_BITS'($urandom), rand_flags());
		write_pte({cfg.root_ppn, slice_of(r.vpn, 0)}, rd_pte({cfg.root_ppn, slice_of(r.vpn, 0)}));
		fail_next = 1'b1;
		issue(1'b1, r, 1'b0, r, "mem_fail", 1'b1);

		r = rand_req();
		map_page(r.vpn, 2, PPN_BITS'($urandom), rand_flags());
		issue(1'b1, r, 1'b0, r, "reuse_first");
		fc = fetch_count;
		issue(1'b1, r, 1'b0, r, "reuse_again");
		assert (fetch_count == fc) else begin
			mismatches++;
			$display("repeated walk over unchanged tables fetched from memory");
		end
		map_page(r.vpn, 2, PPN_BITS'($urandom), rand_flags());
		issue(1'b1, r, 1'b0, r, "after_snoop");
		assert (fetch_count > fc) else begin
			mismatches++;
			$display("walk after snoop did not fetch the rewritten line");
		end

		r = rand_req();
		r2 = rand_req();
		map_page(r.vpn, 2, PPN_BITS'($urandom), rand_flags());
		map_page(r2.vpn, 1, PPN_BITS'($urandom), rand_flags());
		issue(1'b1, r, 1'b1, r2, "both_sides");

		repeat (4) @(posedge clk);
		$display("errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+sim
src/ptw_pkg.sv
src/pte_line_cache.sv
src/pte_decode.sv
src/walk_ctrl.sv
src/ptw_top.sv
sim/tb_ptw.sv

// ==== run.sh ====
#!/bin/sh
# build and run the walker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_ptw -o tb_ptw_sim
./obj_dir/tb_ptw_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
	exit 0
else
	exit 1
fi
